// ==== logic/board_pkg.sv ====
// Board-level types for the key, switch, LED and seven-segment pins.
// Keys and segments are active low, as wired on the board.
package board_pkg;

  // Push keys, 0 means pressed
  typedef logic [3:0] key_t;

  // Slide switches
  typedef logic [9:0] sw_t;

  // One seven-segment digit, bit order gfedcba, 0 lights a segment
  typedef logic [6:0] seg_t;

  // Red LEDs
  typedef logic [9:0] ledr_t;

  // Checksum accumulator, six hex digits wide
  typedef logic [23:0] sum_t;

endpackage : board_pkg

// ==== logic/bus_pkg.sv ====
// Wishbone types shared by the masters, the arbiter and the RAM.
// Word addressing only; no byte selects.
package bus_pkg;

  // Word address into the 256-word RAM
  typedef logic [7:0] wb_addr_t;

  // One RAM word
  typedef logic [15:0] wb_data_t;

  // Arbiter ownership
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_HOST,
    ARB_SUM
  } arb_state_e;

endpackage : bus_pkg

// ==== logic/wb_if.sv ====
// Wishbone classic bundle, single transfers only.
// No err, rty or sel lines.
`timescale 1ns/1ps

interface wb_if import bus_pkg::*; ();

  logic     cyc;
  logic     stb;
  logic     we;
  wb_addr_t adr;
  wb_data_t dat_w;
  wb_data_t dat_r;
  logic     ack;

  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack
  );

endinterface : wb_if

// ==== logic/debouncer.sv ====
// Key debouncer. The raw input is assumed already synchronous to clk.
// The level resets to 1 (key released).
`timescale 1ns/1ps

module debouncer #(
  parameter int DEBOUNCE_CYCLES = 16
) (
  input  logic clk,
  input  logic rst_n,
  input  logic raw,
  output logic level,
  output logic fall
);

  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      level <= 1'b1;
      fall  <= 1'b0;
      cnt   <= '0;
    end else begin
      fall <= 1'b0;
      if (raw == level) begin
        // Input agrees again, restart the stability count
        cnt <= '0;
      end else if (cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
        level <= raw;
        cnt   <= '0;
        // Going 1 to 0 is a press
        fall  <= level & ~raw;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule : debouncer

// ==== logic/wb_arbiter.sv ====
// Round-robin arbiter for two Wishbone classic masters on one slave.
// Grant is held until the owner drops cyc; the loser just stalls.
`timescale 1ns/1ps

module wb_arbiter import bus_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  wb_if.slave  m_host,
  wb_if.slave  m_sum,
  wb_if.master s_ram
);

  arb_state_e state;
  logic       last_sum;

  // ==================================================
  // Ownership state
  // ==================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= ARB_IDLE;
      last_sum <= 1'b1;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (m_host.cyc && m_sum.cyc) begin
            // Both asking, serve the one that waited
            state    <= last_sum ? ARB_HOST : ARB_SUM;
            last_sum <= ~last_sum;
          end else if (m_host.cyc) begin
            state    <= ARB_HOST;
            last_sum <= 1'b0;
          end else if (m_sum.cyc) begin
            state    <= ARB_SUM;
            last_sum <= 1'b1;
          end
        end
        ARB_HOST: if (!m_host.cyc) state <= ARB_IDLE;
        ARB_SUM:  if (!m_sum.cyc) state <= ARB_IDLE;
        default:  state <= ARB_IDLE;
      endcase
    end
  end

  // ==================================================
  // Routing
  // ==================================================
  always_comb begin
    s_ram.cyc   = 1'b0;
    s_ram.stb   = 1'b0;
    s_ram.we    = 1'b0;
    s_ram.adr   = '0;
    s_ram.dat_w = '0;
    if (state == ARB_HOST) begin
      s_ram.cyc   = m_host.cyc;
      s_ram.stb   = m_host.stb;
      s_ram.we    = m_host.we;
      s_ram.adr   = m_host.adr;
      s_ram.dat_w = m_host.dat_w;
    end else if (state == ARB_SUM) begin
      s_ram.cyc   = m_sum.cyc;
      s_ram.stb   = m_sum.stb;
      s_ram.we    = m_sum.we;
      s_ram.adr   = m_sum.adr;
      s_ram.dat_w = m_sum.dat_w;
    end
  end

  // Only the owner gets a response
  assign m_host.ack   = (state == ARB_HOST) & s_ram.ack;
  assign m_host.dat_r = (state == ARB_HOST) ? s_ram.dat_r : '0;
  assign m_sum.ack    = (state == ARB_SUM) & s_ram.ack;
  assign m_sum.dat_r  = (state == ARB_SUM) ? s_ram.dat_r : '0;

endmodule : wb_arbiter

// ==== logic/wb_ram.sv ====
// 256-word RAM behind a Wishbone classic slave port.
// Ack comes one cycle after cyc and stb, one cycle wide; contents survive reset.
`timescale 1ns/1ps

module wb_ram import bus_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  wb_if.slave  bus
);

  wb_data_t mem [256];
  logic     req;

  // New request only when no ack is out, so acks never run back to back
  assign req = bus.cyc & bus.stb & ~bus.ack;

  always_ff @(posedge clk) begin
    if (!rst_n) bus.ack <= 1'b0;
    else        bus.ack <= req;
  end

  always_ff @(posedge clk) begin
    if (req) begin
      if (bus.we) mem[bus.adr] <= bus.dat_w;
      bus.dat_r <= mem[bus.adr];
    end
  end

endmodule : wb_ram

// ==== logic/host_loader.sv ====
// Host write port. One word in flight at a time; load_ready is low
// from acceptance until the Wishbone write is acked.
`timescale 1ns/1ps

module host_loader import bus_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     load_valid,
  input  wb_addr_t load_addr,
  input  wb_data_t load_data,
  output logic     load_ready,
  wb_if.master     bus
);

  logic     pending;
  wb_addr_t adr_q;
  wb_data_t dat_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending <= 1'b0;
    end else if (!pending && load_valid) begin
      pending <= 1'b1;
    end else if (pending && bus.ack) begin
      pending <= 1'b0;
    end
  end

  // Held steady for the whole cycle
  always_ff @(posedge clk) begin
    if (!pending && load_valid) begin
      adr_q <= load_addr;
      dat_q <= load_data;
    end
  end

  assign load_ready = ~pending;
  assign bus.cyc    = pending;
  assign bus.stb    = pending;
  assign bus.we     = 1'b1;
  assign bus.adr    = adr_q;
  assign bus.dat_w  = dat_q;

endmodule : host_loader

// ==== logic/checksum_engine.sv ====
// Sums SUM_LEN consecutive RAM words from base, wrapping at 256.
// Result is modulo 2^24; a go pulse while busy is dropped.
`timescale 1ns/1ps

module checksum_engine import board_pkg::*; import bus_pkg::*; #(
  parameter int SUM_LEN = 8
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     go,
  input  wb_addr_t base,
  wb_if.master     bus,
  output sum_t     sum,
  output logic     busy,
  output logic     done
);

  localparam int CNT_W = $clog2(SUM_LEN) + 1;

  typedef enum logic [1:0] {
    IDLE,
    READ,
    WAIT_ACK
  } state_e;

  state_e           state;
  wb_addr_t         addr;
  logic [CNT_W-1:0] cnt;
  sum_t             acc;
  sum_t             acc_next;
  logic             last_word;

  assign acc_next  = acc + sum_t'(bus.dat_r);
  assign last_word = (cnt == CNT_W'(SUM_LEN - 1));

  // ==================================================
  // Control
  // ==================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
      done  <= 1'b0;
      sum   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (go) begin
            state <= READ;
            done  <= 1'b0;
          end
        end
        // One idle bus cycle between reads lets the arbiter rotate
        READ: state <= WAIT_ACK;
        WAIT_ACK: begin
          if (bus.ack) begin
            if (last_word) begin
              state <= IDLE;
              done  <= 1'b1;
              sum   <= acc_next;
            end else begin
              state <= READ;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Address, count and running total
  always_ff @(posedge clk) begin
    if (state == IDLE && go) begin
      addr <= base;
      cnt  <= '0;
      acc  <= '0;
    end else if (state == WAIT_ACK && bus.ack) begin
      addr <= addr + 1'b1;
      cnt  <= cnt + 1'b1;
      acc  <= acc_next;
    end
  end

  assign busy      = (state != IDLE);
  assign bus.cyc   = (state == WAIT_ACK);
  assign bus.stb   = (state == WAIT_ACK);
  assign bus.we    = 1'b0;
  assign bus.adr   = addr;
  assign bus.dat_w = '0;

endmodule : checksum_engine

// ==== logic/hex_display.sv ====
// Six-digit hex readout, active-low segments, hex0 is the low nibble.
`timescale 1ns/1ps

module hex_display import board_pkg::*; (
  input  sum_t value,
  output seg_t hex0,
  output seg_t hex1,
  output seg_t hex2,
  output seg_t hex3,
  output seg_t hex4,
  output seg_t hex5
);

  function automatic seg_t glyph(input logic [3:0] nib);
    case (nib)
      4'h0: glyph = 7'b1000000;
      4'h1: glyph = 7'b1111001;
      4'h2: glyph = 7'b0100100;
      4'h3: glyph = 7'b0110000;
      4'h4: glyph = 7'b0011001;
      4'h5: glyph = 7'b0010010;
      4'h6: glyph = 7'b0000010;
      4'h7: glyph = 7'b1111000;
      4'h8: glyph = 7'b0000000;
      4'h9: glyph = 7'b0010000;
      4'ha: glyph = 7'b0001000;
      4'hb: glyph = 7'b0000011;
      4'hc: glyph = 7'b1000110;
      4'hd: glyph = 7'b0100001;
      4'he: glyph = 7'b0000110;
      default: glyph = 7'b0001110;
    endcase
  endfunction

  assign hex0 = glyph(value[3:0]);
  assign hex1 = glyph(value[7:4]);
  assign hex2 = glyph(value[11:8]);
  assign hex3 = glyph(value[15:12]);
  assign hex4 = glyph(value[19:16]);
  assign hex5 = glyph(value[23:20]);

endmodule : hex_display

// ==== logic/soc_system_top.sv ====
// Board top: keys, switches, host load port, shared RAM and checksum readout.
// No PLL; clk drives everything. key[3] is a push-button reset, key[0] is go.
// key[1], key[2] and sw[9:8] are unused.
`timescale 1ns/1ps

module soc_system_top import board_pkg::*; import bus_pkg::*; #(
  parameter int DEBOUNCE_CYCLES = 16,
  parameter int SUM_LEN         = 8
) (
  input  logic     clk,
  input  logic     rst_n,
  input  key_t     key,
  input  sw_t      sw,
  input  logic     load_valid,
  input  wb_addr_t load_addr,
  input  wb_data_t load_data,
  output logic     load_ready,
  output seg_t     hex0,
  output seg_t     hex1,
  output seg_t     hex2,
  output seg_t     hex3,
  output seg_t     hex4,
  output seg_t     hex5,
  output ledr_t    ledr
);

  logic but_rst_n;
  logic sys_rst_n;
  logic go;
  logic busy;
  logic done;
  sum_t sum;

  wb_if host_bus ();
  wb_if sum_bus ();
  wb_if ram_bus ();

  // ==================================================
  // Keys
  // ==================================================
  // Debouncers run from the raw reset so key[3] can release itself
  debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_dbc_go (
    .clk   (clk),
    .rst_n (rst_n),
    .raw   (key[0]),
    .level (),
    .fall  (go)
  );

  debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_dbc_rst (
    .clk   (clk),
    .rst_n (rst_n),
    .raw   (key[3]),
    .level (but_rst_n),
    .fall  ()
  );

  assign sys_rst_n = rst_n & but_rst_n;

  // ==================================================
  // Bus masters, arbiter and RAM
  // ==================================================
  host_loader u_host (
    .clk        (clk),
    .rst_n      (sys_rst_n),
    .load_valid (load_valid),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .load_ready (load_ready),
    .bus        (host_bus)
  );

  checksum_engine #(.SUM_LEN(SUM_LEN)) u_sum (
    .clk   (clk),
    .rst_n (sys_rst_n),
    .go    (go),
    .base  (sw[7:0]),
    .bus   (sum_bus),
    .sum   (sum),
    .busy  (busy),
    .done  (done)
  );

  wb_arbiter u_arb (
    .clk    (clk),
    .rst_n  (sys_rst_n),
    .m_host (host_bus),
    .m_sum  (sum_bus),
    .s_ram  (ram_bus)
  );

  wb_ram u_ram (
    .clk   (clk),
    .rst_n (sys_rst_n),
    .bus   (ram_bus)
  );

  // ==================================================
  // Display
  // ==================================================
  hex_display u_hex (
    .value (sum),
    .hex0  (hex0),
    .hex1  (hex1),
    .hex2  (hex2),
    .hex3  (hex3),
    .hex4  (hex4),
    .hex5  (hex5)
  );

  assign ledr = {7'b0, done, busy, sys_rst_n};

endmodule : soc_system_top

// ==== testbench/soc_system_chk.sv ====
// Bus and status properties, bound into soc_system_top.
// Sampled on the rising edge; most are off while the system reset is low.
`timescale 1ns/1ps

module soc_system_chk (
  input logic clk,
  input logic sys_rst_n,
  input logic ram_cyc,
  input logic ram_stb,
  input logic ram_ack,
  input logic host_ack,
  input logic sum_ack,
  input logic busy,
  input logic done,
  input logic load_ready
);

  // RAM only answers an open cycle
  ack_in_cycle: assert property (@(posedge clk) disable iff (!sys_rst_n)
    ram_ack |-> (ram_cyc && ram_stb))
    else $error("RAM ack seen without cyc and stb");

  // Each RAM ack reaches exactly one master
  one_ack: assert property (@(posedge clk) disable iff (!sys_rst_n)
    !(host_ack && sum_ack) && (ram_ack == (host_ack || sum_ack)))
    else $error("Master acks do not match the RAM ack");

  busy_or_done: assert property (@(posedge clk) disable iff (!sys_rst_n)
    !(busy && done))
    else $error("Checksum busy and done are high together");

  ready_after_reset: assert property (@(posedge clk)
    !sys_rst_n |=> load_ready)
    else $error("load_ready low in the cycle after reset");

endmodule : soc_system_chk

bind soc_system_top soc_system_chk u_chk (
  .clk        (clk),
  .sys_rst_n  (sys_rst_n),
  .ram_cyc    (ram_bus.cyc),
  .ram_stb    (ram_bus.stb),
  .ram_ack    (ram_bus.ack),
  .host_ack   (host_bus.ack),
  .sum_ack    (sum_bus.ack),
  .busy       (busy),
  .done       (done),
  .load_ready (load_ready)
);

// ==== testbench/tb_soc_system_top.sv ====
// Testbench for soc_system_top with DEBOUNCE_CYCLES 8 and SUM_LEN 8.
// Expected sums come from a mirror of every host write. Only written words are summed.
// Inputs change on the falling edge, outputs are sampled on the falling edge.
`timescale 1ns/1ps

module tb_soc_system_top import board_pkg::*; import bus_pkg::*; ();

  localparam int DEBOUNCE_CYCLES = 8;
  localparam int SUM_LEN         = 8;
  // About 1900 cycles of tests, mostly the 256-word load, plus margin
  localparam int TIMEOUT_CYCLES  = 4000;
  localparam logic [31:0] SEED   = 32'h95c3e6ee;

  logic     clk;
  logic     rst_n;
  key_t     key;
  sw_t      sw;
  logic     load_valid;
  wb_addr_t load_addr;
  wb_data_t load_data;
  logic     load_ready;
  seg_t     hex0;
  seg_t     hex1;
  seg_t     hex2;
  seg_t     hex3;
  seg_t     hex4;
  seg_t     hex5;
  ledr_t    ledr;

  wb_data_t mirror [256];
  sum_t     exp_sum;
  int       errors;
  int       checks;
  int       err_mark;
  int       tests_run;
  int       tests_failed;
  int       runs_checked;
  int       runs_started;
  int       cycle_count;

  soc_system_top #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
    .SUM_LEN         (SUM_LEN)
  ) DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .key        (key),
    .sw         (sw),
    .load_valid (load_valid),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .load_ready (load_ready),
    .hex0       (hex0),
    .hex1       (hex1),
    .hex2       (hex2),
    .hex3       (hex3),
    .hex4       (hex4),
    .hex5       (hex5),
    .ledr       (ledr)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ==================================================
  // Reference model
  // ==================================================
  // Active-low glyphs, bit order gfedcba
  function automatic seg_t seg_pattern(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'ha: return 7'h08;
      4'hb: return 7'h03;
      4'hc: return 7'h46;
      4'hd: return 7'h21;
      4'he: return 7'h06;
      default: return 7'h0e;
    endcase
  endfunction

  // Sum of SUM_LEN words from base, address wraps at 256
  function automatic sum_t ref_sum(input wb_addr_t base);
    sum_t     s;
    wb_addr_t a;
    s = '0;
    for (int i = 0; i < SUM_LEN; i++) begin
      a = base + 8'(i);
      s = s + {8'h00, mirror[a]};
    end
    return s;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_digits(input sum_t value);
    check("hex0", 32'(hex0), 32'(seg_pattern(value[3:0])));
    check("hex1", 32'(hex1), 32'(seg_pattern(value[7:4])));
    check("hex2", 32'(hex2), 32'(seg_pattern(value[11:8])));
    check("hex3", 32'(hex3), 32'(seg_pattern(value[15:12])));
    check("hex4", 32'(hex4), 32'(seg_pattern(value[19:16])));
    check("hex5", 32'(hex5), 32'(seg_pattern(value[23:20])));
  endtask

  // Compares the digits each time done rises, counts busy rises too
  initial begin : compare_proc
    logic done_prev;
    logic busy_prev;
    done_prev = 1'b0;
    busy_prev = 1'b0;
    forever begin
      @(negedge clk);
      if (ledr[1] && !busy_prev) runs_started++;
      if (ledr[2] && !done_prev) begin
        check_digits(exp_sum);
        runs_checked++;
      end
      done_prev = ledr[2];
      busy_prev = ledr[1];
    end
  end

  // ==================================================
  // Stimulus helpers
  // ==================================================
  task automatic host_write(input wb_addr_t addr, input wb_data_t data);
    @(negedge clk);
    load_valid = 1'b1;
    load_addr  = addr;
    load_data  = data;
    // Accepted at the next rising edge once ready is seen high
    while (!load_ready) @(negedge clk);
    @(negedge clk);
    load_valid = 1'b0;
    mirror[addr] = data;
  endtask

  task automatic press_key(input logic [1:0] idx, input int cycles);
    @(negedge clk);
    key[idx] = 1'b0;
    repeat (cycles) @(negedge clk);
    key[idx] = 1'b1;
  endtask

  task automatic run_checksum(input wb_addr_t base);
    int target;
    target  = runs_checked + 1;
    exp_sum = ref_sum(base);
    @(negedge clk);
    sw = {2'b00, base};
    press_key(2'd0, DEBOUNCE_CYCLES + 4);
    wait (runs_checked >= target);
  endtask

  task automatic begin_test();
    err_mark = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d mismatches", tests_run, name, errors - err_mark);
    end
  endtask

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin : stimulus
    sum_t first_sum;
    int   runs_before;
    void'($urandom(SEED));
    rst_n      = 1'b0;
    key        = '1;
    sw         = '0;
    load_valid = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    exp_sum    = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    begin_test();
    check("load_ready", 32'(load_ready), 32'd1);
    check("ledr[0]", 32'(ledr[0]), 32'd1);
    check("ledr[1]", 32'(ledr[1]), 32'd0);
    check("ledr[2]", 32'(ledr[2]), 32'd0);
    check("ledr[9:3]", 32'(ledr[9:3]), 32'd0);
    check_digits('0);
    end_test("after reset");

    begin_test();
    for (int a = 0; a < 256; a++) begin
      host_write(8'(a), 16'($urandom));
    end
    run_checksum(8'd0);
    first_sum = exp_sum;
    end_test("basic checksum");

    begin_test();
    run_checksum(8'd252);
    end_test("wrapping base");

    // Loads at 100..115 compete with a run over 16..23
    begin_test();
    fork
      run_checksum(8'd16);
      begin
        for (int k = 0; k < 16; k++) begin
          host_write(8'd100 + 8'(k), 16'($urandom));
        end
      end
    join
    run_checksum(8'd100);
    run_checksum(8'd108);
    end_test("contention");

    begin_test();
    runs_before = runs_started;
    press_key(2'd0, DEBOUNCE_CYCLES - 3);
    repeat (2 * DEBOUNCE_CYCLES) @(negedge clk);
    check("ledr[1]", 32'(ledr[1]), 32'd0);
    check("runs after glitch", 32'(runs_started - runs_before), 32'd0);
    run_checksum(8'd40);
    repeat (2 * DEBOUNCE_CYCLES) @(negedge clk);
    check("runs after held press", 32'(runs_started - runs_before), 32'd1);
    end_test("key bounce");

    begin_test();
    @(negedge clk);
    key[3] = 1'b0;
    repeat (DEBOUNCE_CYCLES + 4) @(negedge clk);
    check("ledr[0]", 32'(ledr[0]), 32'd0);
    check("ledr[2]", 32'(ledr[2]), 32'd0);
    check_digits('0);
    key[3] = 1'b1;
    while (!ledr[0]) @(negedge clk);
    @(negedge clk);
    check("load_ready", 32'(load_ready), 32'd1);
    run_checksum(8'd0);
    // Display must show the sum from the first run again
    check_digits(first_sum);
    end_test("key reset");

    $display("%0d tests, %0d failed, %0d checks, %0d mismatches",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_soc_system_top

// ==== src.f ====
logic/board_pkg.sv
logic/bus_pkg.sv
logic/wb_if.sv
logic/debouncer.sv
logic/wb_arbiter.sv
logic/wb_ram.sv
logic/host_loader.sv
logic/checksum_engine.sv
logic/hex_display.sv
logic/soc_system_top.sv
testbench/soc_system_chk.sv
testbench/tb_soc_system_top.sv

// ==== Makefile ====
# Verilator build and run for the soc_system_top testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_system_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ALL TESTS PASSED

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; status=$$?; echo "$$out"; \
	if [ $$status -eq 0 ] && echo "$$out" | grep -q "$(PASS_TEXT)"; then \
	  exit 0; else exit 1; fi

clean:
	rm -rf $(BUILD_DIR)
